// File: fp_cluster.f
+incdir+sim
rtl/fcore_pkg.sv
rtl/register_slice.sv
rtl/fp_saturator.sv
rtl/fp_comparator.sv
rtl/register_file.sv
rtl/fp_exec_cluster.sv
sim/tb_fp_cluster.sv

// File: run_sim.sh
#!/bin/sh
# Builds the cluster testbench with Verilator and runs it once.
# The run passes only when the testbench prints its pass message.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_fp_cluster \
    -f fp_cluster.f

output=$(./obj_dir/Vtb_fp_cluster)
echo "$output"

if echo "$output" | grep -qx "Done: no errors"; then
    exit 0
else
    exit 1
fi

// File: sim/fp_ref_model.svh
// Reference model of the cluster for inclusion inside the testbench module.
// Needs pipeline_depth and the fcore_pkg import in the including scope.
// Results come from the model's own registers at the issue edge.

`ifndef FP_REF_MODEL_SVH
`define FP_REF_MODEL_SVH

logic [31:0] model_regs  [16];
logic        pend_valid  [pipeline_depth];
result_t     pend_result [pipeline_depth];

// In sign and magnitude order -0 sits below +0 and a larger negative magnitude is lower
function automatic logic total_less(input logic [31:0] a, input logic [31:0] b);
    if (a[31] != b[31]) begin
        return a[31];
    end
    if (a[31]) begin
        return a[30:0] > b[30:0];
    end
    return a[30:0] < b[30:0];
endfunction

function automatic logic [31:0] model_result(input issue_t op, input logic [31:0] a,
                                             input logic [31:0] b);
    logic hit;
    if (op.unit == unit_saturator) begin
        if (op.mode == 2'd1) begin
            return total_less(a, b) ? a : b;
        end
        return total_less(a, b) ? b : a;
    end
    case (op.mode)
        2'd0:    hit = total_less(a, b);
        2'd1:    hit = total_less(a, b) || (a == b);
        default: hit = (a == b);
    endcase
    // Single-precision 1.0 for true
    return hit ? 32'h3f80_0000 : 32'h0000_0000;
endfunction

task automatic model_reset();
    for (int i = 0; i < 16; i++) begin
        model_regs[i] = '0;
    end
    for (int i = 0; i < pipeline_depth; i++) begin
        pend_valid[i] = 1'b0;
    end
endtask

// Each rising edge enters the new issue, then commits the host write and the oldest result
task automatic model_edge(input issue_t op, input logic write, input logic [3:0] addr,
                          input logic [31:0] wdata);
    logic    out_valid;
    result_t out_result;
    result_t fresh;
    out_valid  = pend_valid[pipeline_depth-1];
    out_result = pend_result[pipeline_depth-1];
    fresh.data = model_result(op, model_regs[op.src_a], model_regs[op.src_b]);
    fresh.dest = op.dest;
    for (int i = pipeline_depth - 1; i > 0; i--) begin
        pend_valid[i]  = pend_valid[i-1];
        pend_result[i] = pend_result[i-1];
    end
    pend_valid[0]  = op.valid && (op.unit == unit_saturator || op.unit == unit_comparator);
    pend_result[0] = fresh;
    if (write) begin
        model_regs[addr] = wdata;
    end
    if (out_valid) begin
        model_regs[out_result.dest] = out_result.data;
    end
endtask

`endif

// File: sim/tb_fp_cluster.sv
// Testbench for fp_exec_cluster with random traffic from a fixed seed.
// Registers are compared with the reference model through the host read port.

`timescale 1ns/10ps
`default_nettype none

module tb_fp_cluster;

    import fcore_pkg::*;

    localparam int pipeline_depth = 5;
    // The tests take roughly 1300 cycles
    localparam int cycle_limit = 2000;

    logic        clock = 1'b0;
    logic        reset;
    issue_t      issue;
    logic        host_write;
    logic [3:0]  host_addr;
    logic [31:0] host_wdata;
    logic [3:0]  host_raddr;
    logic [31:0] host_rdata;
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    int unsigned seed_value;

    `include "fp_ref_model.svh"

    fp_exec_cluster #(
        .pipeline_depth (pipeline_depth)
    ) dut0 (
        .clock      (clock),
        .reset      (reset),
        .issue      (issue),
        .host_write (host_write),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_raddr (host_raddr),
        .host_rdata (host_rdata)
    );

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Run stopped, the tests did not finish within %0d cycles", cycle_limit);
            $display("Checks: %0d, errors: %0d", check_count, error_count);
            $display("Done: errors found");
            $finish;
        end
    end

    // Advance one edge, keep the model in step, and return 1 ns after the edge
    task automatic tick();
        @(posedge clock);
        if (!reset) begin
            model_reset();
        end else begin
            model_edge(issue, host_write, host_addr, host_wdata);
        end
        #1;
    endtask

    task automatic drain();
        issue      = '0;
        host_write = 1'b0;
        repeat (pipeline_depth + 1) tick();
    endtask

    task automatic host_store(input logic [3:0] addr, input logic [31:0] data);
        host_write = 1'b1;
        host_addr  = addr;
        host_wdata = data;
        tick();
        host_write = 1'b0;
    endtask

    task automatic send_issue(input issue_t op);
        issue = op;
        tick();
        issue = '0;
    endtask

    task automatic compare_rdata(input logic [3:0] addr, input logic [31:0] expected);
        check_count++;
        if (host_rdata !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: host_rdata for r%0d = %h, expected %h",
                     $time, addr, host_rdata, expected);
        end
    endtask

    task automatic check_all_regs();
        for (int i = 0; i < 16; i++) begin
            host_raddr = 4'(i);
            #2;
            compare_rdata(4'(i), model_regs[i]);
            tick();
        end
    endtask

    function automatic logic [31:0] random_value();
        case ($urandom_range(0, 4))
            0:       return 32'h0000_0000;
            1:       return 32'h8000_0000;
            // Close exponents make near ties likely
            2:       return {1'($urandom), 8'd127 + 8'($urandom_range(0, 3)),
                             23'($urandom_range(0, 7))};
            default: return $urandom;
        endcase
    endfunction

    // Fills all registers with a mix of values, equal pairs and sign-flipped pairs
    task automatic load_operands();
        logic [31:0] vals [16];
        int          pick;
        for (int i = 0; i < 16; i++) begin
            pick = (i == 0) ? 0 : int'($urandom_range(0, i - 1));
            case ((i == 0) ? 0 : $urandom_range(0, 3))
                1:       vals[i] = vals[pick];
                2:       vals[i] = vals[pick] ^ 32'h8000_0000;
                default: vals[i] = random_value();
            endcase
            host_store(4'(i), vals[i]);
        end
    endtask

    function automatic issue_t random_issue(input unit_code_t unit);
        issue_t op;
        op.valid = 1'b1;
        op.unit  = unit;
        op.mode  = (unit == unit_saturator) ? 2'($urandom_range(0, 1)) : 2'($urandom);
        op.src_a = 4'($urandom);
        op.src_b = ($urandom_range(0, 3) == 0) ? op.src_a : 4'($urandom);
        op.dest  = 4'($urandom);
        return op;
    endfunction

    // traffic 0 is saturator only, 1 comparator only, 2 mixed every cycle
    task automatic run_batches(input int batches, input int ops, input int traffic);
        issue_t     op;
        logic [3:0] last_dest;
        int         roll;
        for (int b = 0; b < batches; b++) begin
            load_operands();
            last_dest = 4'd0;
            for (int n = 0; n < ops; n++) begin
                roll = int'($urandom_range(0, 9));
                if (traffic == 0 || (traffic == 2 && roll < 5)) begin
                    op = random_issue(unit_saturator);
                end else begin
                    op = random_issue(unit_comparator);
                end
                if (traffic == 2) begin
                    // The previous destination is still in the pipeline
                    if (roll[0]) op.src_a = last_dest;
                    if (roll == 8) op.src_b = last_dest;
                    if (roll == 9) op.unit = 3'd1;
                    if (roll == 4) op.valid = 1'b0;
                end
                last_dest = op.dest;
                send_issue(op);
                if (traffic != 2 && roll < 3) tick();
            end
            drain();
            check_all_regs();
        end
    endtask

    // Destination holds its old value through edge pipeline_depth-1
    task automatic check_latency(input unit_code_t unit, input logic collide);
        issue_t      op;
        logic [31:0] old_value;
        logic [31:0] new_value;
        host_store(4'd1, 32'h4000_0000);
        host_store(4'd2, 32'hc000_0000);
        host_store(4'd3, 32'h1234_5678);
        op       = '0;
        op.valid = 1'b1;
        op.unit  = unit;
        op.src_a = 4'd2;
        op.src_b = 4'd1;
        op.dest  = 4'd3;
        old_value  = model_regs[3];
        new_value  = model_result(op, model_regs[2], model_regs[1]);
        issue      = op;
        host_raddr = op.dest;
        tick();
        issue = '0;
        for (int k = 0; k < pipeline_depth; k++) begin
            if (collide && k == pipeline_depth - 1) begin
                // Host write sampled on the writeback edge
                host_write = 1'b1;
                host_addr  = op.dest;
                host_wdata = ~new_value;
            end
            #2;
            compare_rdata(op.dest, old_value);
            tick();
            host_write = 1'b0;
        end
        #2;
        compare_rdata(op.dest, new_value);
        tick();
    endtask

    initial begin
        seed_value = $urandom(32'h81ca_fe47);
        reset      = 1'b0;
        issue      = '0;
        host_write = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        host_raddr = '0;
        repeat (3) tick();
        reset = 1'b1;
        for (int i = 0; i < 16; i++) begin
            host_raddr = 4'(i);
            #2;
            compare_rdata(4'(i), 32'h0000_0000);
            tick();
        end
        load_operands();
        check_all_regs();
        run_batches(6, 24, 0);
        run_batches(6, 24, 1);
        run_batches(4, 40, 2);
        check_latency(unit_saturator, 1'b0);
        check_latency(unit_comparator, 1'b0);
        check_latency(unit_saturator, 1'b1);
        drain();
        check_all_regs();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/fp_exec_cluster.sv
// Min/max and compare slice of the execution cluster.
// Operands are read from the register file in the issue cycle, with no
// hazard check against results still in flight.
// pipeline_depth sets the writeback latency of both units and must be 3 or more.

`timescale 1ns/10ps
`default_nettype none

module fp_exec_cluster #(
    parameter int pipeline_depth = 5
) (
    input  logic                                    clock,
    input  logic                                    reset,
    input  fcore_pkg::issue_t                       issue,
    input  logic                                    host_write,
    input  logic [fcore_pkg::reg_addr_width-1:0]    host_addr,
    input  logic [fcore_pkg::data_width-1:0]        host_wdata,
    input  logic [fcore_pkg::reg_addr_width-1:0]    host_raddr,
    output logic [fcore_pkg::data_width-1:0]        host_rdata
);

    import fcore_pkg::*;

    logic [data_width-1:0] operand_a;
    logic [data_width-1:0] operand_b;
    logic                  sat_valid;
    result_t               sat_result;
    logic                  cmp_valid;
    result_t               cmp_result;

    register_file regfile (
        .clock      (clock),
        .reset      (reset),
        .src_a      (issue.src_a),
        .src_b      (issue.src_b),
        .host_raddr (host_raddr),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .host_rdata (host_rdata),
        .host_write (host_write),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .sat_valid  (sat_valid),
        .sat_result (sat_result),
        .cmp_valid  (cmp_valid),
        .cmp_result (cmp_result)
    );

    fp_saturator #(
        .pipeline_depth (pipeline_depth),
        .unit_code      (unit_saturator)
    ) saturator (
        .clock        (clock),
        .reset        (reset),
        .issue        (issue),
        .operand_a    (operand_a),
        .operand_b    (operand_b),
        .result_valid (sat_valid),
        .result       (sat_result)
    );

    fp_comparator #(
        .pipeline_depth (pipeline_depth),
        .unit_code      (unit_comparator)
    ) comparator (
        .clock        (clock),
        .reset        (reset),
        .issue        (issue),
        .operand_a    (operand_a),
        .operand_b    (operand_b),
        .result_valid (cmp_valid),
        .result       (cmp_result)
    );

endmodule

`default_nettype wire

// File: rtl/register_file.sv
// 16 x 32 register file with three combinational read ports.
// Reads in the cycle of a write return the old value.
// A writeback overrides a host write to the same address in the same cycle.
// Only one unit may write back per cycle.

`timescale 1ns/10ps
`default_nettype none

module register_file (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic [fcore_pkg::reg_addr_width-1:0]    src_a,
    input  logic [fcore_pkg::reg_addr_width-1:0]    src_b,
    input  logic [fcore_pkg::reg_addr_width-1:0]    host_raddr,
    output logic [fcore_pkg::data_width-1:0]        operand_a,
    output logic [fcore_pkg::data_width-1:0]        operand_b,
    output logic [fcore_pkg::data_width-1:0]        host_rdata,
    input  logic                                    host_write,
    input  logic [fcore_pkg::reg_addr_width-1:0]    host_addr,
    input  logic [fcore_pkg::data_width-1:0]        host_wdata,
    input  logic                                    sat_valid,
    input  fcore_pkg::result_t                      sat_result,
    input  logic                                    cmp_valid,
    input  fcore_pkg::result_t                      cmp_result
);

    import fcore_pkg::*;

    localparam int n_regs = 2 ** reg_addr_width;

    logic [data_width-1:0] regs [n_regs];

    // Every register reads 0 after reset
    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < n_regs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (host_write) begin
                regs[host_addr] <= host_wdata;
            end
            // Later assignments win, so writebacks take priority over the host
            if (sat_valid) begin
                regs[sat_result.dest] <= sat_result.data;
            end
            if (cmp_valid) begin
                regs[cmp_result.dest] <= cmp_result.data;
            end
        end
    end

    assign operand_a  = regs[src_a];
    assign operand_b  = regs[src_b];
    assign host_rdata = regs[host_raddr];

    // Both units have the same latency and issue is one per cycle,
    // so two writebacks in one cycle point at a broken issue stream
    single_writeback: assert property (
        @(posedge clock) disable iff (!reset)
        !(sat_valid && cmp_valid)
    ) else $error("register_file: saturator and comparator write back together");

endmodule

`default_nettype wire

// File: rtl/fp_comparator.sv
// Compare unit returning single-precision 1.0 or 0.0.
// Less-than uses total bit order and equality compares the raw bits,
// so -0 and +0 are not equal and a NaN equals an identical NaN.
// Latency matches fp_saturator for the same pipeline_depth.

`timescale 1ns/10ps
`default_nettype none

module fp_comparator #(
    parameter int                    pipeline_depth = 5,
    parameter fcore_pkg::unit_code_t unit_code      = fcore_pkg::unit_comparator
) (
    input  logic                                clock,
    input  logic                                reset,
    input  fcore_pkg::issue_t                   issue,
    input  logic [fcore_pkg::data_width-1:0]    operand_a,
    input  logic [fcore_pkg::data_width-1:0]    operand_b,
    output logic                                result_valid,
    output fcore_pkg::result_t                  result
);

    import fcore_pkg::*;

    logic                      accept;
    logic                      a_sign;
    logic                      b_sign;
    logic                      a_mag_gt;
    logic                      a_mag_lt;
    logic                      a_less;
    logic                      stage_valid;
    logic                      lt_q;
    logic                      eq_q;
    mode_t                     mode_q;
    logic [reg_addr_width-1:0] dest_q;
    logic                      hit;
    logic                      early_valid;
    result_t                   early_result;

    assign accept = issue.valid && (issue.unit == unit_code);

    assign a_sign   = operand_a[data_width-1];
    assign b_sign   = operand_b[data_width-1];
    assign a_mag_gt = operand_a[data_width-2:0] > operand_b[data_width-2:0];
    assign a_mag_lt = operand_a[data_width-2:0] < operand_b[data_width-2:0];

    // A negative value is below any non-negative one, and among two
    // negatives the larger magnitude is the lower value
    assign a_less = (a_sign != b_sign) ? a_sign : (a_sign ? a_mag_gt : a_mag_lt);

    always_ff @(posedge clock) begin
        if (accept) begin
            lt_q   <= a_less;
            eq_q   <= operand_a == operand_b;
            mode_q <= issue.mode;
            dest_q <= issue.dest;
        end
    end

    always_comb begin
        case (mode_q)
            cmp_lt:  hit = lt_q;
            cmp_le:  hit = lt_q | eq_q;
            cmp_eq:  hit = eq_q;
            default: hit = eq_q;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            stage_valid <= 1'b0;
            early_valid <= 1'b0;
        end else begin
            stage_valid <= accept;
            early_valid <= stage_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (stage_valid) begin
            early_result.data <= hit ? fp_one : '0;
            early_result.dest <= dest_q;
        end
    end

    register_slice #(
        .payload_t (result_t),
        .N_STAGES  (pipeline_depth - 2)
    ) result_pipe (
        .clock       (clock),
        .reset       (reset),
        .in_valid    (early_valid),
        .in_payload  (early_result),
        .out_valid   (result_valid),
        .out_payload (result)
    );

endmodule

`default_nettype wire

// File: rtl/fp_saturator.sv
// Min/max unit for single-precision values in total bit order.
// NaN and denormals are ordered by their bits, with no special handling.
// Latency from the issue edge to the result strobe is pipeline_depth-1 edges
// and the register file commits one edge later. pipeline_depth must be 3 or more.

`timescale 1ns/10ps
`default_nettype none

module fp_saturator #(
    parameter int                    pipeline_depth = 5,
    parameter fcore_pkg::unit_code_t unit_code      = fcore_pkg::unit_saturator
) (
    input  logic                                clock,
    input  logic                                reset,
    input  fcore_pkg::issue_t                   issue,
    input  logic [fcore_pkg::data_width-1:0]    operand_a,
    input  logic [fcore_pkg::data_width-1:0]    operand_b,
    output logic                                result_valid,
    output fcore_pkg::result_t                  result
);

    import fcore_pkg::*;

    logic                      accept;
    logic                      stage_valid;
    logic [data_width-1:0]     a_q;
    logic [data_width-1:0]     b_q;
    logic                      a_gt_b_q;
    logic                      both_neg_q;
    mode_t                     mode_q;
    logic [reg_addr_width-1:0] dest_q;
    logic                      a_above_b;
    logic                      take_a;
    logic                      early_valid;
    result_t                   early_result;

    assign accept = issue.valid && (issue.unit == unit_code);

    // Stage 1 of the front end holds the operands and the raw integer compare
    always_ff @(posedge clock) begin
        if (accept) begin
            a_q        <= operand_a;
            b_q        <= operand_b;
            a_gt_b_q   <= $signed(operand_a) > $signed(operand_b);
            both_neg_q <= operand_a[data_width-1] & operand_b[data_width-1];
            mode_q     <= issue.mode;
            dest_q     <= issue.dest;
        end
    end

    // Two negative values order the other way round as integers,
    // so the signed compare is flipped when both signs are set
    assign a_above_b = a_gt_b_q ^ both_neg_q;

    always_comb begin
        case (mode_q)
            mode_min: take_a = !a_above_b;
            mode_max: take_a = a_above_b;
            // Undefined saturator modes fall back to the maximum
            default:  take_a = a_above_b;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            stage_valid <= 1'b0;
            early_valid <= 1'b0;
        end else begin
            stage_valid <= accept;
            early_valid <= stage_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (stage_valid) begin
            early_result.data <= take_a ? a_q : b_q;
            early_result.dest <= dest_q;
        end
    end

    register_slice #(
        .payload_t (result_t),
        .N_STAGES  (pipeline_depth - 2)
    ) result_pipe (
        .clock       (clock),
        .reset       (reset),
        .in_valid    (early_valid),
        .in_payload  (early_result),
        .out_valid   (result_valid),
        .out_payload (result)
    );

    // The strobe is sampled pipeline_depth edges after the edge that took the issue
    result_has_issue: assert property (
        @(posedge clock) disable iff (!reset)
        result_valid |-> $past(accept, pipeline_depth)
    ) else $error("fp_saturator: result without a matching issue");

endmodule

`default_nettype wire

// File: rtl/register_slice.sv
// Fixed delay line for a valid bit and its payload.
// There is no back-pressure, so every stage advances on every clock.
// With N_STAGES of 0 the output follows the input combinationally.

`timescale 1ns/10ps
`default_nettype none

module register_slice #(
    parameter type payload_t = logic,
    parameter int  N_STAGES  = 1
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_payload,
    output logic     out_valid,
    output payload_t out_payload
);

    generate
        if (N_STAGES == 0) begin : g_bypass
            assign out_valid   = in_valid;
            assign out_payload = in_payload;
        end else begin : g_stages
            logic     valid_q   [N_STAGES];
            payload_t payload_q [N_STAGES];

            // Payload stages shift on every clock alongside the valid chain
            always_ff @(posedge clock) begin
                if (!reset) begin
                    for (int i = 0; i < N_STAGES; i++) begin
                        valid_q[i] <= 1'b0;
                    end
                end else begin
                    valid_q[0] <= in_valid;
                    for (int i = 1; i < N_STAGES; i++) begin
                        valid_q[i] <= valid_q[i-1];
                    end
                end
            end

            always_ff @(posedge clock) begin
                payload_q[0] <= in_payload;
                for (int i = 1; i < N_STAGES; i++) begin
                    payload_q[i] <= payload_q[i-1];
                end
            end

            assign out_valid   = valid_q[N_STAGES-1];
            assign out_payload = payload_q[N_STAGES-1];
        end
    endgenerate

    stage_count_ok: assert property (@(posedge clock) N_STAGES >= 0)
        else $error("register_slice: N_STAGES is negative");

endmodule

`default_nettype wire

// File: rtl/fcore_pkg.sv
// Shared widths, codes and payload types of the execution cluster.
// The operand layout is IEEE single precision and the width is fixed at 32.
// Unit codes must match the ones that the issue stage of the core emits.

`default_nettype none

package fcore_pkg;

    localparam int data_width     = 32;
    localparam int reg_addr_width = 4;

    // Unit select field of an issued operation
    typedef logic [2:0] unit_code_t;

    localparam unit_code_t unit_saturator  = 3'd6;
    localparam unit_code_t unit_comparator = 3'd7;

    // Operation mode, read differently by each unit
    typedef logic [1:0] mode_t;

    // Saturator modes
    localparam mode_t mode_max = 2'd0;
    localparam mode_t mode_min = 2'd1;

    // Comparator modes; code 3 behaves as equal
    localparam mode_t cmp_lt = 2'd0;
    localparam mode_t cmp_le = 2'd1;
    localparam mode_t cmp_eq = 2'd2;

    // Single-precision 1.0, the true value of a comparison
    localparam logic [data_width-1:0] fp_one = 32'h3f80_0000;

    typedef struct packed {
        logic                      valid;
        unit_code_t                unit;
        mode_t                     mode;
        logic [reg_addr_width-1:0] src_a;
        logic [reg_addr_width-1:0] src_b;
        logic [reg_addr_width-1:0] dest;
    } issue_t;

    typedef struct packed {
        logic [data_width-1:0]     data;
        logic [reg_addr_width-1:0] dest;
    } result_t;

endpackage

`default_nettype wire
